// File: all.f
rtl/mvu_pkg.sv
rtl/data_mem.sv
rtl/mem_arbiter.sv
rtl/mvu_agu.sv
rtl/mvu_unit.sv
rtl/mvu_top.sv
verif/mvu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the MVU array testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mvu_tb -f all.f -o mvu_sim \
    && ./obj_dir/mvu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: verif/mvu_tb.sv
// Testbench for the MVU array with clock, reset, memory model, random jobs, checks and watchdog
`default_nettype none

module mvu_tb import mvu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int nmvu    = 4;
    localparam int n_fill  = 256;  // Controller writes that fill the whole memory
    localparam int n_probe = 16;   // Read-back probes after the fill
    localparam int n_busy  = 8;    // Write plus read pairs during contention
    localparam int n_jobs  = 6;    // Unsigned, signed, then four concurrent jobs
    localparam int n_ctrl  = n_fill + n_probe + 1 + 2 * n_busy + n_jobs;
    localparam int wd_cycles = 200 * n_jobs + 20 * n_ctrl + 5;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [nmvu-1:0]   start;
    mvu_cfg_t          cfg [nmvu];
    logic [nmvu-1:0]   done;
    logic [nmvu-1:0]   irq;
    logic              rdc_en;
    logic [addr_w-1:0] rdc_addr;
    logic              rdc_grnt;
    logic [data_w-1:0] rdc_word;
    logic              wrc_en;
    logic [addr_w-1:0] wrc_addr;
    logic [data_w-1:0] wrc_word;
    logic              wrc_grnt;

    logic [data_w-1:0] model [256];          // Expected memory contents
    int                seed = 32'h232c;
    int                errors = 0;
    int                irq_count [nmvu] = '{default: 0};
    int                jobs_started [nmvu] = '{default: 0};
    logic [nmvu-1:0]   prev_done;            // Monitor history, one cycle back
    logic [nmvu-1:0]   prev_irq;
    logic [nmvu-1:0]   prev_start;

    mvu_top #(.nmvu(nmvu)) uut (
        .clk(clk), .rst_n(rst_n), .start(start), .cfg(cfg), .done(done), .irq(irq),
        .rdc_en(rdc_en), .rdc_addr(rdc_addr), .rdc_grnt(rdc_grnt), .rdc_word(rdc_word),
        .wrc_en(wrc_en), .wrc_addr(wrc_addr), .wrc_word(wrc_word), .wrc_grnt(wrc_grnt)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    // Controller write, enable held until granted
    task automatic ctrl_write(input logic [7:0] a, input logic [15:0] d);
        @(negedge clk);
        wrc_en   = 1'b1;
        wrc_addr = a;
        wrc_word = d;
        @(posedge clk);
        while (!wrc_grnt) @(posedge clk);
        model[a] = d;            // Write landed at this edge
        @(negedge clk);
        wrc_en = 1'b0;
    endtask

    // Controller read, data taken one cycle after the grant
    task automatic ctrl_read(input logic [7:0] a, output logic [15:0] d);
        @(negedge clk);
        rdc_en   = 1'b1;
        rdc_addr = a;
        @(posedge clk);
        while (!rdc_grnt) @(posedge clk);
        @(negedge clk);
        rdc_en = 1'b0;
        d      = rdc_word;       // Registered by the memory at the grant edge
    endtask

    // Random job over addresses 0..189, clear of the busy and result regions
    task automatic make_cfg(input int unit, input logic sgn, input logic [7:0] obase);
        mvu_cfg_t c;
        logic [31:0] rnd;
        rnd           = $random(seed);
        c.ibaseaddr   = {2'b00, rnd[5:0]};
        c.ilength     = rnd[11:6];
        c.quant_shift = {1'b0, rnd[15:12]};
        c.istride     = 8'((rnd >> 17) % 3);
        c.obaseaddr   = obase;
        c.d_signed    = sgn;
        cfg[unit]     = c;
    endtask

    // Sum of the walked words, widened per d_signed, shifted down, low word kept
    function automatic logic [15:0] expect_result(input mvu_cfg_t c);
        int          total;
        int          w;
        int          res;
        logic [7:0]  a;
        total = 0;
        a     = c.ibaseaddr;
        for (int i = 0; i <= int'(c.ilength); i++) begin
            if (c.d_signed) begin
                w = $signed(model[a]);
            end else begin
                w = model[a];
            end
            total = total + w;
            a     = a + c.istride;  // Wraps at 256
        end
        res = total >>> c.quant_shift;
        return res[15:0];
    endfunction

    task automatic start_units(input logic [nmvu-1:0] mask);
        @(negedge clk);
        start = mask;
        @(negedge clk);
        start = '0;
        for (int i = 0; i < nmvu; i++) begin
            if (mask[i]) begin
                jobs_started[i]++;
                assert (!done[i]) else begin
                    errors++;
                    $display("Unit %0d kept done high after its start", i);
                end
            end
        end
    endtask

    task automatic wait_done(input logic [nmvu-1:0] mask, input int limit);
        int n;
        n = 0;
        while ((done & mask) != mask && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert ((done & mask) == mask) else begin
            errors++;
            $display("Units %b did not raise done within %0d cycles", mask, limit);
        end
    endtask

    task automatic check_job(input string name, input int unit);
        logic [15:0] got;
        logic [15:0] exp;
        exp = expect_result(cfg[unit]);
        ctrl_read(cfg[unit].obaseaddr, got);
        check_word(name, exp, got);
        model[cfg[unit].obaseaddr] = exp;  // Memory now holds the result
    endtask

    // Done and irq protocol monitor, sampled before the edge updates
    always @(posedge clk) begin
        if (!rst_n) begin
            prev_done  = '0;
            prev_irq   = '0;
            prev_start = '0;
        end else begin
            for (int i = 0; i < nmvu; i++) begin
                assert ((done[i] && !prev_done[i]) == irq[i]) else begin
                    errors++;
                    $display("Unit %0d: done rise and irq pulse are not together", i);
                end
                assert (!(irq[i] && prev_irq[i])) else begin
                    errors++;
                    $display("Unit %0d: irq stayed high for more than one cycle", i);
                end
                assert (done[i] || !prev_done[i] || prev_start[i]) else begin
                    errors++;
                    $display("Unit %0d: done fell without a start", i);
                end
                if (irq[i]) irq_count[i]++;
            end
            prev_done  = done;
            prev_irq   = irq;
            prev_start = start;
        end
    end

    initial begin
        #(wd_cycles * 10);
        $display("Watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [7:0]  a;
        logic [15:0] got;
        rst_n    = 1'b0;
        start    = '0;
        cfg      = '{default: '0};
        rdc_en   = 1'b0;
        rdc_addr = '0;
        wrc_en   = 1'b0;
        wrc_addr = '0;
        wrc_word = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        assert (done == '0 && irq == '0) else begin
            errors++;
            $display("done or irq is high after reset");
        end

        // Memory access: fill everything, then probe random addresses
        for (int i = 0; i < n_fill; i++) ctrl_write(8'(i), 16'($random(seed)));
        for (int i = 0; i < n_probe; i++) begin
            a = 8'($random(seed));
            ctrl_read(a, got);
            check_word("mem_access", model[a], got);
        end

        make_cfg(0, 1'b0, 8'hf0);                 // Single unsigned job
        start_units(4'b0001);
        wait_done(4'b0001, 200);
        check_job("job_unsigned", 0);

        make_cfg(2, 1'b1, 8'hf1);                 // Signed job, first word forced negative
        ctrl_write(cfg[2].ibaseaddr, 16'h8000 | 16'($random(seed)));
        start_units(4'b0100);
        wait_done(4'b0100, 200);
        check_job("job_signed", 2);

        // Contention: all units plus controller traffic in 0xc0..0xef
        for (int i = 0; i < nmvu; i++) make_cfg(i, 1'($random(seed)), 8'(8'hf2 + i));
        start_units(4'b1111);
        for (int k = 0; k < n_busy; k++) begin
            ctrl_write(8'(8'hc0 + (32'($random(seed)) >> 1) % 48), 16'($random(seed)));
            a = 8'(8'hc0 + (32'($random(seed)) >> 1) % 48);
            ctrl_read(a, got);
            check_word("busy_read", model[a], got);
        end
        wait_done(4'b1111, 200 * nmvu);
        for (int i = 0; i < nmvu; i++) check_job("job_contention", i);

        repeat (2) @(negedge clk);
        for (int i = 0; i < nmvu; i++) begin
            assert (irq_count[i] == jobs_started[i]) else begin
                errors++;
                $display("ERROR irq_count unit %0d: expected %0d, actual %0d",
                         i, jobs_started[i], irq_count[i]);
            end
        end

        $display("Checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mvu_top.sv
// MVU array top: units, controller ports, memory arbiter and shared data memory
`default_nettype none

module mvu_top import mvu_pkg::*; #(
    parameter int nmvu = 4  // Number of units
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [nmvu-1:0]   start,      // Per-unit job start strobes
    input  wire mvu_cfg_t          cfg [nmvu], // Per-unit job configuration
    output logic      [nmvu-1:0]   done,
    output logic      [nmvu-1:0]   irq,
    input  wire logic              rdc_en,     // Controller read
    input  wire logic [addr_w-1:0] rdc_addr,
    output logic                   rdc_grnt,
    output logic      [data_w-1:0] rdc_word,   // Valid one cycle after rdc_grnt
    input  wire logic              wrc_en,     // Controller write
    input  wire logic [addr_w-1:0] wrc_addr,
    input  wire logic [data_w-1:0] wrc_word,
    output logic                   wrc_grnt    // Write lands in this cycle
);

    localparam int n_req = nmvu + 2;

    mem_req_t             reqs [n_req];  // 0 wrc, 1 rdc, 2.. units
    logic     [n_req-1:0] grants;
    mem_req_t             mem_req;       // Winner to the memory
    logic    [data_w-1:0] rd_word;       // Read data broadcast

    assign reqs[0]  = '{en: wrc_en, we: 1'b1, addr: wrc_addr, wdata: wrc_word};
    assign reqs[1]  = '{en: rdc_en, we: 1'b0, addr: rdc_addr, wdata: '0};
    assign wrc_grnt = grants[0];
    assign rdc_grnt = grants[1];
    assign rdc_word = rd_word;

    for (genvar i = 0; i < nmvu; i++) begin : g_unit
        mvu_unit u_unit (
            .clk     (clk),
            .rst_n   (rst_n),
            .start   (start[i]),
            .cfg     (cfg[i]),
            .req     (reqs[i+2]),
            .grant   (grants[i+2]),
            .rd_word (rd_word),
            .done    (done[i]),
            .irq     (irq[i])
        );
    end

    mem_arbiter #(
        .n_req (n_req)
    ) u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (reqs),
        .grant   (grants),
        .mem_req (mem_req)
    );

    data_mem u_mem (
        .clk     (clk),
        .req     (mem_req),
        .rd_word (rd_word)
    );

endmodule

`default_nettype wire

// File: rtl/mvu_unit.sv
// MVU unit: configuration latch, job FSM, accumulator and result write-back
`default_nettype none

module mvu_unit import mvu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start,    // Job start strobe
    input  wire mvu_cfg_t          cfg,      // Sampled on start
    output mem_req_t               req,      // Request to the arbiter
    input  wire logic              grant,    // Request accepted this cycle
    input  wire logic [data_w-1:0] rd_word,  // Broadcast read data
    output logic                   done,     // Level, high from job end to next start
    output logic                   irq       // One-cycle pulse at job end
);

    typedef enum logic [1:0] {
        st_idle,   // No job
        st_read,   // Issuing input reads
        st_drain,  // Last read data in flight
        st_write   // Requesting the result write
    } state_t;

    state_t                   state;
    mvu_cfg_t                 cfg_q;     // Latched job configuration
    mvu_cfg_t                 agu_cfg;   // Live cfg on the start edge, latched otherwise
    logic                     rd_pend;   // rd_word belongs to this unit
    logic signed [acc_w-1:0]  acc;       // Running sum of input words
    logic signed [acc_w-1:0]  acc_sh;    // Quantized sum
    logic        [acc_w-1:0]  ext_word;  // Returned word widened to acc_w
    logic        [addr_w-1:0] rd_addr;
    logic                     rd_last;
    logic                     rd_step;

    assign agu_cfg = start ? cfg : cfg_q;
    assign rd_step = (state == st_read) && grant;

    mvu_agu u_agu (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (start),
        .step  (rd_step),
        .cfg   (agu_cfg),
        .addr  (rd_addr),
        .last  (rd_last)
    );

    // Sign or zero extension as configured
    assign ext_word = cfg_q.d_signed ? {{(acc_w-data_w){rd_word[data_w-1]}}, rd_word}
                                     : {{(acc_w-data_w){1'b0}}, rd_word};
    assign acc_sh   = acc >>> cfg_q.quant_shift;  // Arithmetic, keeps the sign

    // Memory request, held stable until granted
    always_comb begin
        req       = '0;
        req.en    = (state == st_read) || (state == st_write);
        req.we    = (state == st_write);
        req.addr  = (state == st_write) ? cfg_q.obaseaddr : rd_addr;
        req.wdata = acc_sh[data_w-1:0];  // Low word of the scaled sum
    end

    always_ff @(posedge clk) begin
        cfg_q <= start ? cfg : cfg_q;    // Payload, no reset
        if (start) begin
            acc <= '0;
        end else if (rd_pend) begin
            acc <= acc + ext_word;       // One word per returned read
        end
    end

    // Job sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            rd_pend <= 1'b0;
            done    <= 1'b0;
            irq     <= 1'b0;
        end else begin
            rd_pend <= rd_step;          // Data returns one cycle after the grant
            irq     <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_read;
                        done  <= 1'b0;   // Falls the cycle after the new start
                    end
                end
                st_read: begin
                    if (grant && rd_last) begin
                        state <= st_drain;
                    end
                end
                st_drain: state <= st_write;  // Last word lands in acc this cycle
                st_write: begin
                    if (grant) begin
                        state <= st_idle;
                        done  <= 1'b1;
                        irq   <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Controller must wait for done before restarting a unit
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == st_idle);

endmodule

`default_nettype wire

// File: rtl/mvu_agu.sv
// Input address generator stepping base address, stride and remaining word count
`default_nettype none

module mvu_agu import mvu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              load,   // Start of job
    input  wire logic              step,   // Current address was granted
    input  wire mvu_cfg_t          cfg,
    output logic      [addr_w-1:0] addr,   // Address of the next input word
    output logic                   last    // Current address is the final one
);

    logic [len_w-1:0] cnt;  // Words left after the current one

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr <= '0;
            cnt  <= '0;
        end else if (load) begin
            addr <= cfg.ibaseaddr;
            cnt  <= cfg.ilength;          // Length already holds count minus one
        end else if (step) begin
            addr <= addr + cfg.istride;   // Wraps modulo memory depth
            if (!last) begin
                cnt <= cnt - 1'b1;        // Hold at zero once the walk is over
            end
        end
    end

    assign last = (cnt == '0);

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
// Data memory arbiter: fixed priority for controller ports, round robin for the units
`default_nettype none

module mem_arbiter import mvu_pkg::*; #(
    parameter int n_req = 6  // Controller write, controller read, then the units
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire mem_req_t         req [n_req],  // 0 wrc, 1 rdc, 2.. units
    output logic      [n_req-1:0] grant,        // One-hot or zero, same cycle as req
    output mem_req_t              mem_req       // Winner forwarded to the memory
);

    localparam int n_units = n_req - 2;                             // Round-robin requesters
    localparam int ptr_w   = (n_units > 1) ? $clog2(n_units) : 1;  // Pointer width

    logic [ptr_w-1:0] ptr;      // Unit with top priority this cycle
    logic [ptr_w-1:0] win;      // Unit picked by the round robin
    logic             win_vld;  // A unit won this cycle
    logic [n_req-1:0] req_en;   // Request valids as a vector

    always_comb begin
        for (int i = 0; i < n_req; i++) begin
            req_en[i] = req[i].en;
        end
    end

    // Grant decision
    always_comb begin
        int unsigned idx;
        idx     = 0;
        grant   = '0;
        win     = ptr;
        win_vld = 1'b0;
        if (req[0].en) begin
            grant[0] = 1'b1;                              // Controller write first
        end else if (req[1].en) begin
            grant[1] = 1'b1;                              // Then controller read
        end else begin
            // Walk backwards so the unit closest to ptr is picked last and wins
            for (int k = n_units - 1; k >= 0; k--) begin
                idx = ptr + k;
                if (idx >= n_units) begin
                    idx = idx - n_units;                  // Wrap around the unit ring
                end
                if (req[idx+2].en) begin
                    win     = idx[ptr_w-1:0];
                    win_vld = 1'b1;
                end
            end
            if (win_vld) begin
                grant[win+2] = 1'b1;
            end
        end
    end

    // Forward the granted request, idle request otherwise
    always_comb begin
        mem_req = '0;
        for (int i = 0; i < n_req; i++) begin
            if (grant[i]) begin
                mem_req = req[i];
            end
        end
    end

    // Pointer moves to the unit after the last granted one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (win_vld) begin
            ptr <= (win == ptr_w'(n_units - 1)) ? '0 : win + 1'b1;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));
    a_grant_active: assert property (@(posedge clk) disable iff (!rst_n)
        (grant & ~req_en) == '0);

endmodule

`default_nettype wire

// File: rtl/data_mem.sv
// Single-port synchronous data memory with one-cycle read latency
`default_nettype none

module data_mem import mvu_pkg::*; (
    input  wire logic              clk,
    input  wire mem_req_t          req,      // Winning request from the arbiter
    output logic      [data_w-1:0] rd_word   // Read data, valid the cycle after the grant
);

    localparam int depth = 2 ** addr_w;  // 256 words

    logic [data_w-1:0] mem [depth];  // Storage, contents undefined after reset

    // One access per cycle: write lands now, read data is registered
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;  // Visible to any later read
            end else begin
                rd_word <= mem[req.addr];    // Held until the next read
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mvu_pkg.sv
// Shared widths, memory request struct and job configuration struct for the MVU array
`default_nettype none

package mvu_pkg;

    localparam int data_w  = 16;  // Data memory word width
    localparam int addr_w  = 8;   // Data memory address width, 256 words
    localparam int len_w   = 6;   // Job length, holds word count minus one
    localparam int acc_w   = 24;  // Accumulator width
    localparam int shift_w = 5;   // Quantizer shift amount width

    // One access request towards the data memory
    typedef struct packed {
        logic              en;     // Request valid
        logic              we;     // 1 write, 0 read
        logic [addr_w-1:0] addr;   // Word address
        logic [data_w-1:0] wdata;  // Write data, ignored on reads
    } mem_req_t;

    // Job configuration, sampled by a unit on its start strobe
    typedef struct packed {
        logic [addr_w-1:0]  ibaseaddr;    // First input word
        logic [addr_w-1:0]  istride;      // Address step between input words
        logic [len_w-1:0]   ilength;      // Input words minus one
        logic [addr_w-1:0]  obaseaddr;    // Result word address
        logic               d_signed;     // Input words are two's complement
        logic [shift_w-1:0] quant_shift;  // Arithmetic right shift of the sum
    } mvu_cfg_t;

endpackage

`default_nettype wire
